// ==== project.f ====
rtl/gpio_pkg.sv
rtl/gpio_regs.sv
rtl/gpio_pad.sv
rtl/gpio_event_collect.sv
rtl/gpio_top.sv
test/gpio_checker.sv
test/tb_gpio.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the GPIO testbench with Verilator
cd "$(dirname "$0")" && \
  verilator --binary --timing --assert -j 0 --top-module tb_gpio -f project.f && \
  ./obj_dir/Vtb_gpio || exit 1

// ==== test/tb_gpio.sv ====
// Testbench for the GPIO controller
// Drives the register strobes and the pin inputs of gpio_top and checks
// pin drive, input readback, glitch rejection, edge events and the IRQ.
// Read responses are compared by a separate process against a queue.

`timescale 1ns/10ps

module tb_gpio import gpio_pkg::*; ();

  localparam int NUM_PINS       = 12;
  localparam int FILTER_CYCLES  = 3;
  localparam int SETTLE_CYCLES  = FILTER_CYCLES + 6;
  localparam int ITERATIONS     = 40;
  localparam int TIMEOUT_CYCLES = 6000;

  logic                sys_clk;
  logic                arst_n;
  reg_bus_t            reg_bus;
  logic [REG_DW-1:0]   rdata;
  logic                rvalid;
  logic [NUM_PINS-1:0] gpio_in;
  logic [NUM_PINS-1:0] gpio_out;
  logic [NUM_PINS-1:0] gpio_oe;
  logic                irq;

  // Stimulus and model state
  logic [31:0]         rng_state;
  logic [31:0]         rnd;
  logic [31:0]         exp_q[$];
  string               name_q[$];
  string               test_name;
  int                  cycle_count;
  int                  glitch_len;
  logic [NUM_PINS-1:0] rise_en_m;
  logic [NUM_PINS-1:0] fall_en_m;
  logic [NUM_PINS-1:0] level_m;
  logic [NUM_PINS-1:0] pend_m;

  gpio_top #(
    .NUM_PINS      (NUM_PINS),
    .FILTER_CYCLES (FILTER_CYCLES)
  ) dut (
    .i_sys_clk (sys_clk),
    .i_arst_n  (arst_n),
    .i_reg     (reg_bus),
    .o_rdata   (rdata),
    .o_rvalid  (rvalid),
    .i_gpio    (gpio_in),
    .o_gpio    (gpio_out),
    .o_gpio_oe (gpio_oe),
    .o_irq     (irq)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Expected pending bits after a settled input change
  function automatic logic [NUM_PINS-1:0] expect_pending(
    input logic [NUM_PINS-1:0] old_level,
    input logic [NUM_PINS-1:0] new_level,
    input logic [NUM_PINS-1:0] rise_en,
    input logic [NUM_PINS-1:0] fall_en,
    input logic [NUM_PINS-1:0] prev
  );
    logic [NUM_PINS-1:0] rise;
    logic [NUM_PINS-1:0] fall;
    rise = ~old_level & new_level;
    fall = old_level & ~new_level;
    return prev | (rise & rise_en) | (fall & fall_en);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge sys_clk);
    #1;
  endtask

  task automatic write_reg(input gpio_reg_e addr, input logic [31:0] data);
    reg_bus.wr    = 1'b1;
    reg_bus.addr  = addr;
    reg_bus.wdata = data;
    next_cycle();
    reg_bus.wr = 1'b0;
  endtask

  // Idle cycle after the strobe keeps reads apart
  task automatic read_reg(input gpio_reg_e addr, input logic [31:0] expected);
    exp_q.push_back(expected);
    name_q.push_back(test_name);
    reg_bus.rd   = 1'b1;
    reg_bus.addr = addr;
    next_cycle();
    reg_bus.rd = 1'b0;
    next_cycle();
  endtask

  // Read data is stable around the falling edge
  always @(negedge sys_clk) begin
    if (arst_n && rvalid) begin
      assert (exp_q.size() > 0) else fail_run("read response arrived with no read outstanding");
      check_value(name_q.pop_front(), exp_q.pop_front(), rdata);
    end
  end

  always @(posedge sys_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) fail_run("timeout, the run exceeded its cycle limit");
  end

  initial begin
    rng_state   = 32'd48825;
    cycle_count = 0;
    arst_n      = 1'b0;
    reg_bus     = '0;
    gpio_in     = '0;
    repeat (3) @(posedge sys_clk);
    #1;
    arst_n = 1'b1;

    test_name = "reset_state";
    check_value(test_name, 32'd0, 32'(gpio_oe));
    check_value(test_name, 32'd0, 32'(gpio_out));
    check_value(test_name, 32'd0, {31'd0, irq});
    read_reg(REG_DIR, 32'd0);
    read_reg(REG_OUT, 32'd0);
    read_reg(REG_IN, 32'd0);
    read_reg(REG_RISE_EN, 32'd0);
    read_reg(REG_FALL_EN, 32'd0);
    read_reg(REG_PENDING, 32'd0);

    test_name = "drive_regs";
    for (int i = 0; i < ITERATIONS; i++) begin
      rnd = next_random();
      write_reg(REG_DIR, rnd);
      check_value(test_name, 32'(rnd[NUM_PINS-1:0]), 32'(gpio_oe));
      read_reg(REG_DIR, 32'(rnd[NUM_PINS-1:0]));
      rnd = next_random();
      write_reg(REG_OUT, rnd);
      check_value(test_name, 32'(rnd[NUM_PINS-1:0]), 32'(gpio_out));
      read_reg(REG_OUT, 32'(rnd[NUM_PINS-1:0]));
    end

    // Edge enables are still 0 here
    test_name = "input_readback";
    for (int i = 0; i < ITERATIONS; i++) begin
      rnd     = next_random();
      gpio_in = rnd[NUM_PINS-1:0];
      repeat (SETTLE_CYCLES) next_cycle();
      read_reg(REG_IN, 32'(gpio_in));
    end

    // All edges enabled so a leaked glitch would show as pending
    test_name = "glitch_reject";
    write_reg(REG_RISE_EN, 32'hffff_ffff);
    write_reg(REG_FALL_EN, 32'hffff_ffff);
    level_m = gpio_in;
    pend_m  = '0;
    for (int i = 0; i < ITERATIONS; i++) begin
      rnd        = next_random();
      glitch_len = 1 + int'(next_random() % 32'(FILTER_CYCLES - 1));
      gpio_in    = level_m ^ rnd[NUM_PINS-1:0];
      repeat (glitch_len) next_cycle();
      gpio_in = level_m;
      repeat (SETTLE_CYCLES) next_cycle();
      read_reg(REG_IN, 32'(level_m));
      read_reg(REG_PENDING, 32'(pend_m));
    end

    test_name = "edge_irq";
    for (int i = 0; i < ITERATIONS; i++) begin
      rnd       = next_random();
      rise_en_m = rnd[NUM_PINS-1:0];
      write_reg(REG_RISE_EN, rnd);
      rnd       = next_random();
      fall_en_m = rnd[NUM_PINS-1:0];
      write_reg(REG_FALL_EN, rnd);
      rnd     = next_random();
      gpio_in = rnd[NUM_PINS-1:0];
      repeat (SETTLE_CYCLES) next_cycle();
      pend_m  = expect_pending(level_m, gpio_in, rise_en_m, fall_en_m, pend_m);
      level_m = gpio_in;
      check_value(test_name, {31'd0, pend_m != '0}, {31'd0, irq});
      read_reg(REG_PENDING, 32'(pend_m));
      // Clear a random subset
      rnd = next_random();
      write_reg(REG_PENDING, rnd);
      pend_m = pend_m & ~rnd[NUM_PINS-1:0];
      check_value(test_name, {31'd0, pend_m != '0}, {31'd0, irq});
      read_reg(REG_PENDING, 32'(pend_m));
    end

    while (exp_q.size() != 0) next_cycle();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== test/gpio_checker.sv ====
// Assertions bound into the GPIO top level
// Watches read response timing, the interrupt against the pending
// bits and the pin enables right after reset.

`timescale 1ns/10ps

module gpio_checker #(
  parameter int NUM_PINS = 12
) (
  input logic                i_sys_clk,
  input logic                i_arst_n,
  input logic                i_rd,
  input logic                i_rvalid,
  input logic                i_irq,
  input logic [NUM_PINS-1:0] i_pending,
  input logic [NUM_PINS-1:0] i_gpio_oe
);

  // Response only in the cycle after a read strobe
  a_rvalid_after_rd: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
    i_rvalid |-> $past(i_rd)) else $error("read valid without a read strobe before it");

  a_rvalid_single: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
    i_rvalid |=> !i_rvalid) else $error("read valid held for two cycles");

  // IRQ is the plain OR, no delay
  a_irq_or: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
    i_irq == (|i_pending)) else $error("interrupt differs from the OR of pending bits");

  a_oe_after_reset: assert property (@(posedge i_sys_clk)
    $rose(i_arst_n) |-> (i_gpio_oe == '0)) else $error("output enables not 0 after reset");

endmodule

bind gpio_top gpio_checker #(.NUM_PINS(NUM_PINS)) u_checker (
  .i_sys_clk (i_sys_clk),
  .i_arst_n  (i_arst_n),
  .i_rd      (i_reg.rd),
  .i_rvalid  (o_rvalid),
  .i_irq     (o_irq),
  .i_pending (pending),
  .i_gpio_oe (o_gpio_oe)
);

// ==== rtl/gpio_top.sv ====
// GPIO controller top level
// Connects the register block, one pad cell per pin and the event
// collector. The pins leave as separate input, output and output-enable
// vectors, ready for the bidirectional buffers of the pad ring.
// NUM_PINS and FILTER_CYCLES are set here and passed down.

`timescale 1ns/10ps

module gpio_top import gpio_pkg::*; #(
  // Number of pins, 1 to 32
  parameter int NUM_PINS      = 12,
  // Input filter length in cycles, 1 to 15
  parameter int FILTER_CYCLES = 3
) (
  input  logic                i_sys_clk,
  input  logic                i_arst_n,
  // Register access
  input  reg_bus_t            i_reg,
  output logic [REG_DW-1:0]   o_rdata,
  output logic                o_rvalid,
  // Pins
  input  logic [NUM_PINS-1:0] i_gpio,
  output logic [NUM_PINS-1:0] o_gpio,
  output logic [NUM_PINS-1:0] o_gpio_oe,
  // Interrupt
  output logic                o_irq
);

  // Register block to pads
  pin_ctrl_t [NUM_PINS-1:0] pin_ctrl;
  // Pads to collector
  pin_stat_t [NUM_PINS-1:0] pin_stat;

  // Register block to collector
  logic [NUM_PINS-1:0] rise_en;
  logic [NUM_PINS-1:0] fall_en;
  logic [NUM_PINS-1:0] clear;

  // Collector readback
  logic [NUM_PINS-1:0] level;
  logic [NUM_PINS-1:0] pending;

  gpio_regs #(
    .NUM_PINS (NUM_PINS)
  ) u_regs (
    .i_sys_clk (i_sys_clk),
    .i_arst_n  (i_arst_n),
    .i_reg     (i_reg),
    .i_level   (level),
    .i_pending (pending),
    .o_ctrl    (pin_ctrl),
    .o_rise_en (rise_en),
    .o_fall_en (fall_en),
    .o_clear   (clear),
    .o_rdata   (o_rdata),
    .o_rvalid  (o_rvalid)
  );

  // One pad cell per pin
  for (genvar i = 0; i < NUM_PINS; i++) begin : g_pad
    gpio_pad #(
      .FILTER_CYCLES (FILTER_CYCLES)
    ) u_pad (
      .i_sys_clk (i_sys_clk),
      .i_arst_n  (i_arst_n),
      .i_ctrl    (pin_ctrl[i]),
      .i_pin     (i_gpio[i]),
      .o_pin     (o_gpio[i]),
      .o_pin_oe  (o_gpio_oe[i]),
      .o_stat    (pin_stat[i])
    );
  end

  gpio_event_collect #(
    .NUM_PINS (NUM_PINS)
  ) u_collect (
    .i_sys_clk (i_sys_clk),
    .i_arst_n  (i_arst_n),
    .i_stat    (pin_stat),
    .i_rise_en (rise_en),
    .i_fall_en (fall_en),
    .i_clear   (clear),
    .o_level   (level),
    .o_pending (pending),
    .o_irq     (o_irq)
  );

endmodule

// ==== rtl/gpio_event_collect.sv ====
// GPIO event collector
// Gathers the status of all pad cells, masks their edge pulses with the
// rise and fall enables and keeps one sticky pending bit per pin.
// The interrupt is the plain OR of the pending bits.

`timescale 1ns/10ps

module gpio_event_collect import gpio_pkg::*; #(
  parameter int NUM_PINS = 12
) (
  input  logic                     i_sys_clk,
  input  logic                     i_arst_n,
  // Per-pin status from the pad cells
  input  pin_stat_t [NUM_PINS-1:0] i_stat,
  // Enables and clear from the register block
  input  logic [NUM_PINS-1:0]      i_rise_en,
  input  logic [NUM_PINS-1:0]      i_fall_en,
  input  logic [NUM_PINS-1:0]      i_clear,
  // Readback
  output logic [NUM_PINS-1:0]      o_level,
  output logic [NUM_PINS-1:0]      o_pending,
  output logic                     o_irq
);

  // Unpacked status fields
  logic [NUM_PINS-1:0] level;
  logic [NUM_PINS-1:0] rise;
  logic [NUM_PINS-1:0] fall;

  // Enabled edges of this cycle
  logic [NUM_PINS-1:0] set;

  // Sticky pending bits
  logic [NUM_PINS-1:0] pending_q;

  // Split the status records into vectors
  always_comb begin
    for (int i = 0; i < NUM_PINS; i++) begin
      level[i] = i_stat[i].level;
      rise[i]  = i_stat[i].rise;
      fall[i]  = i_stat[i].fall;
    end
  end

  // Only enabled edges count
  assign set = (rise & i_rise_en) | (fall & i_fall_en);

  // Set has priority over a clear in the same cycle
  always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~i_clear) | set;
    end
  end

  assign o_level   = level;
  assign o_pending = pending_q;

  // No extra register on the interrupt
  assign o_irq = |pending_q;

endmodule

// ==== rtl/gpio_pad.sv ====
// Pad-side cell of one GPIO pin
// Drives the pin output and enable from the register block, brings the
// raw input through a two-flop synchronizer and a glitch filter, and
// reports the accepted level with one-cycle rise and fall pulses.

`timescale 1ns/10ps

module gpio_pad import gpio_pkg::*; #(
  parameter int FILTER_CYCLES = 3
) (
  input  logic      i_sys_clk,
  input  logic      i_arst_n,
  input  pin_ctrl_t i_ctrl,
  // Raw pin input, asynchronous to the clock
  input  logic      i_pin,
  output logic      o_pin,
  output logic      o_pin_oe,
  output pin_stat_t o_stat
);

  // Counter wide enough for FILTER_CYCLES-1
  localparam int CNT_W = $clog2(FILTER_CYCLES + 1);

  // Synchronizer chain, sync_q[1] is the usable sample
  logic [1:0]       sync_q;

  // Glitch filter state
  logic [CNT_W-1:0] cnt_q;
  logic             level_q;
  logic             differs;
  logic             accept;

  // Edge pulses
  logic             rise_q;
  logic             fall_q;

  // Output drive
  assign o_pin    = i_ctrl.out;
  assign o_pin_oe = i_ctrl.oe;

  always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], i_pin};
    end
  end

  // Sample disagrees with the accepted level
  assign differs = sync_q[1] ^ level_q;
  // Last of FILTER_CYCLES differing samples in a row
  assign accept  = differs && (cnt_q == CNT_W'(FILTER_CYCLES - 1));

  always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt_q   <= '0;
      level_q <= 1'b0;
      rise_q  <= 1'b0;
      fall_q  <= 1'b0;
    end else begin
      // Pulses default low
      rise_q <= 1'b0;
      fall_q <= 1'b0;
      if (!differs) begin
        // Glitch ended, start over
        cnt_q <= '0;
      end else if (accept) begin
        cnt_q   <= '0;
        level_q <= sync_q[1];
        rise_q  <= sync_q[1];
        fall_q  <= ~sync_q[1];
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign o_stat.level = level_q;
  assign o_stat.rise  = rise_q;
  assign o_stat.fall  = fall_q;

endmodule

// ==== rtl/gpio_regs.sv ====
// GPIO register block
// Decodes single-cycle write and read strobes against the register map.
// Holds direction, output and edge-enable registers, turns a write to
// the pending register into a clear vector and returns registered
// read data with a one-cycle valid pulse.

`timescale 1ns/10ps

module gpio_regs import gpio_pkg::*; #(
  parameter int NUM_PINS = 12
) (
  input  logic                       i_sys_clk,
  input  logic                       i_arst_n,
  // Register access
  input  reg_bus_t                   i_reg,
  // Readback from the collector
  input  logic [NUM_PINS-1:0]        i_level,
  input  logic [NUM_PINS-1:0]        i_pending,
  // Pin drive
  output pin_ctrl_t [NUM_PINS-1:0]   o_ctrl,
  // Event control
  output logic [NUM_PINS-1:0]        o_rise_en,
  output logic [NUM_PINS-1:0]        o_fall_en,
  output logic [NUM_PINS-1:0]        o_clear,
  // Read response
  output logic [REG_DW-1:0]          o_rdata,
  output logic                       o_rvalid
);

  // Control registers
  logic [NUM_PINS-1:0] dir_q;
  logic [NUM_PINS-1:0] out_q;
  logic [NUM_PINS-1:0] rise_en_q;
  logic [NUM_PINS-1:0] fall_en_q;

  // Write data cut to the implemented pins
  logic [NUM_PINS-1:0] wr_bits;

  // Read path
  logic [REG_DW-1:0]   rd_sel;
  logic [REG_DW-1:0]   rdata_q;
  logic                rvalid_q;

  // Upper bits of wdata are dropped here
  assign wr_bits = i_reg.wdata[NUM_PINS-1:0];

  // Register writes
  always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dir_q     <= '0;
      out_q     <= '0;
      rise_en_q <= '0;
      fall_en_q <= '0;
    end else if (i_reg.wr) begin
      case (i_reg.addr)
        REG_DIR:     dir_q     <= wr_bits;
        REG_OUT:     out_q     <= wr_bits;
        REG_RISE_EN: rise_en_q <= wr_bits;
        REG_FALL_EN: fall_en_q <= wr_bits;
        // REG_IN, REG_PENDING and unknown addresses keep the registers
        default: ;
      endcase
    end
  end

  // Clear strobe for the pending bits
  // lasts exactly as long as the write strobe
  assign o_clear = (i_reg.wr && (i_reg.addr == REG_PENDING)) ? wr_bits : '0;

  // Read select, unused upper bits stay 0
  always_comb begin
    rd_sel = '0;
    case (i_reg.addr)
      REG_DIR:     rd_sel[NUM_PINS-1:0] = dir_q;
      REG_OUT:     rd_sel[NUM_PINS-1:0] = out_q;
      REG_IN:      rd_sel[NUM_PINS-1:0] = i_level;
      REG_RISE_EN: rd_sel[NUM_PINS-1:0] = rise_en_q;
      REG_FALL_EN: rd_sel[NUM_PINS-1:0] = fall_en_q;
      REG_PENDING: rd_sel[NUM_PINS-1:0] = i_pending;
      // Unknown address reads 0
      default:     rd_sel = '0;
    endcase
  end

  // Read response, data held between reads
  always_ff @(posedge i_sys_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rdata_q  <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= i_reg.rd;
      if (i_reg.rd) begin
        rdata_q <= rd_sel;
      end
    end
  end

  assign o_rdata  = rdata_q;
  assign o_rvalid = rvalid_q;

  // Pin drive follows the registers directly
  always_comb begin
    for (int i = 0; i < NUM_PINS; i++) begin
      o_ctrl[i].oe  = dir_q[i];
      o_ctrl[i].out = out_q[i];
    end
  end

  assign o_rise_en = rise_en_q;
  assign o_fall_en = fall_en_q;

endmodule

// ==== rtl/gpio_pkg.sv ====
// Shared types of the GPIO controller
// Holds the register map, the strobed register access and the
// per-pin drive and status records that pass between the blocks.
// Modules pull these in with a wildcard import in their header.

package gpio_pkg;

  // Register data width, wide enough for up to 32 pins
  localparam int REG_DW = 32;

  // Register map
  typedef enum logic [2:0] {
    // Direction, a 1 bit drives the pin
    REG_DIR     = 3'd0,
    // Output value
    REG_OUT     = 3'd1,
    // Filtered input level, read only
    REG_IN      = 3'd2,
    // Rising-edge enables
    REG_RISE_EN = 3'd3,
    // Falling-edge enables
    REG_FALL_EN = 3'd4,
    // Sticky pending bits, write 1 to clear
    REG_PENDING = 3'd5
  } gpio_reg_e;

  // One register access, strobes valid for a single cycle
  typedef struct packed {
    logic              wr;
    logic              rd;
    gpio_reg_e         addr;
    logic [REG_DW-1:0] wdata;
  } reg_bus_t;

  // Drive of one pin
  typedef struct packed {
    logic oe;
    logic out;
  } pin_ctrl_t;

  // Filtered status of one pin, rise and fall are one-cycle pulses
  typedef struct packed {
    logic level;
    logic rise;
    logic fall;
  } pin_stat_t;

endpackage
